// File: Makefile
SRCS = $(wildcard source/*.sv sim/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_ddr2: all.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ddr2 -f all.f

run: obj_dir/Vtb_ddr2
	@out="$$(./obj_dir/Vtb_ddr2)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// File: all.f
source/ddr2_pkg.sv
source/ddr2_init_seq.sv
source/ddr2_refresh_timer.sv
source/ddr2_cmd_arbiter.sv
source/ddr2_cmd_top.sv
sim/ddr2_properties.sv
sim/tb_ddr2.sv

// File: sim/ddr2_properties.sv
`timescale 1ns/100ps

module ddr2_properties (
	input logic                 CLK_n,
	input logic                 RST,
	input logic                 init_done,
	input logic                 user_ready,
	input logic                 ref_ack,
	input ddr2_pkg::arb_state_e state,
	input ddr2_pkg::ddr2_pins_t pins
);
	import ddr2_pkg::*;

	a_ready_closed: assert property (@(posedge CLK_n) disable iff (!RST)
		!init_done |-> !user_ready) // port closed during init
		else $error("user_ready high while init_done low");

	a_ack_single: assert property (@(posedge CLK_n) disable iff (!RST)
		ref_ack |=> !ref_ack) // one cycle pulse
		else $error("ref_ack longer than one cycle");

	a_ack_from_arsr: assert property (@(posedge CLK_n) disable iff (!RST)
		ref_ack |-> $past(state) == REF_ARSR) // set while leaving REF_ARSR
		else $error("ref_ack outside REF_ARSR");

	a_arsr_after_prch: assert property (@(posedge CLK_n) disable iff (!RST)
		(init_done && pins.cmd == ARSR) |-> $past(pins.cmd) == PRCH)
		else $error("ARSR on pins without PRCH before it");

endmodule

bind ddr2_cmd_arbiter ddr2_properties u_props (
	.CLK_n      (CLK_n),
	.RST        (RST),
	.init_done  (init_done),
	.user_ready (user_ready),
	.ref_ack    (ref_ack),
	.state      (state),
	.pins       (pins)
);

// File: sim/tb_ddr2.sv
`timescale 1ns/100ps

module tb_ddr2;
	import ddr2_pkg::*;

	localparam int USER_CMDS    = 60; // random traffic length
	localparam int STALL_CYCLES = 3;  // decision cycle, PRCH, ARSR
	localparam int RUN_CYCLES   = 16 + CKE_WAIT + INIT_STEPS * STEP_GAP + SETTLE_WAIT
		+ USER_CMDS * 4 + 2 * (REFRESH_INTERVAL + 20) + 100;
	localparam ddr2_pins_t NOOP_PINS  = '{NOOP, 13'h400, 2'd0};
	localparam ddr2_pins_t REF_P_PINS = '{PRCH, 13'h400, 2'd0}; // refresh precharge-all
	localparam ddr2_pins_t REF_A_PINS = '{ARSR, 13'h400, 2'd0};

	logic        CLK_n = 1'b0;
	logic        RST;
	ddr2_pins_t  user_cmd;
	logic        user_valid;
	logic        user_ready;
	logic        cke;
	ddr2_pins_t  pins;
	logic        init_done;

	ddr2_pins_t  init_table [INIT_STEPS]; // expected init commands
	ddr2_pins_t  exp_q [$];               // accepted, not yet on pins
	ddr2_pins_t  mon_exp;
	logic [31:0] lcg_state = 32'd46387;
	int          cyc = 0;                 // rising edges so far
	int          done_cyc;                // edge of init_done rise
	int          sent_cnt = 0;
	int          seen_cnt = 0;            // user commands observed on pins
	int          ref_pairs = 0;
	int          ref_arsr_cyc;
	logic        mon_on = 1'b0;
	logic        prev_prch = 1'b0;        // refresh PRCH seen last cycle

	ddr2_cmd_top u_dut (
		.CLK_n      (CLK_n),
		.RST        (RST),
		.user_cmd   (user_cmd),
		.user_valid (user_valid),
		.user_ready (user_ready),
		.cke        (cke),
		.pins       (pins),
		.init_done  (init_done)
	);

	always #5 CLK_n = ~CLK_n; // 10 ns period

	always @(posedge CLK_n) cyc <= cyc + 1;

	task automatic abort_run();
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
		abort_run();
	endtask

	task automatic report_failure(input string why);
		$display("%s", why);
		abort_run();
	endtask

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic ddr2_pins_t rand_user_cmd();
		logic [31:0] r;
		ddr2_pins_t  c;
		r = next_rand();
		case (r[31:30]) // no PRCH or ARSR from the user
			2'd0:    c.cmd = ACTV;
			2'd1:    c.cmd = READ;
			2'd2:    c.cmd = WRTE;
			default: c.cmd = BTRM;
		endcase
		c.addr = r[28:16];
		c.bank = r[13:12];
		return c;
	endfunction

	task automatic load_init_table();
		init_table[0]  = '{PRCH, 13'h400, 2'd1};
		init_table[1]  = '{MRST, 13'h000, 2'd2};
		init_table[2]  = '{MRST, 13'h000, 2'd3};
		init_table[3]  = '{MRST, 13'h380, 2'd1};
		init_table[4]  = '{MRST, 13'h532, 2'd0};
		init_table[5]  = '{PRCH, 13'h400, 2'd0};
		init_table[6]  = '{ARSR, 13'h400, 2'd0};
		init_table[7]  = '{ARSR, 13'h400, 2'd0};
		init_table[8]  = '{MRST, 13'h432, 2'd0};
		init_table[9]  = '{MRST, 13'h380, 2'd1};
		init_table[10] = '{MRST, 13'h000, 2'd1};
	endtask

	task automatic next_cycle();
		@(posedge CLK_n);
		#1; // drive and sample off the edge
	endtask

	// holds valid until the handshake
	task automatic send_cmd(input ddr2_pins_t c, output int waited);
		logic rdy;
		waited = 0;
		user_cmd = c;
		user_valid = 1'b1;
		do begin
			rdy = user_ready; // value the coming edge sees
			next_cycle();
			if (!rdy) waited++;
			if (waited > STALL_CYCLES + 2)
				report_failure("user command not accepted in time");
		end while (!rdy);
		user_valid = 1'b0;
		exp_q.push_back(c); // due on pins at the next negedge
		sent_cnt++;
	endtask

	// pins checker once init is done
	always @(negedge CLK_n) begin
		if (mon_on) begin
			if (pins.cmd inside {ACTV, READ, WRTE, BTRM})
				seen_cnt++; // user command on pins
			if (exp_q.size() != 0) begin
				mon_exp = exp_q.pop_front(); // one cycle after acceptance
				assert (pins == mon_exp)
					else report_mismatch("pins", 32'(pins), 32'(mon_exp));
			end else if (prev_prch) begin
				assert (pins == REF_A_PINS)
					else report_mismatch("pins", 32'(pins), 32'(REF_A_PINS));
				assert (!user_ready) else report_failure("user_ready high during ARSR");
				ref_pairs++;
				ref_arsr_cyc = cyc;
				prev_prch = 1'b0;
			end else if (pins == REF_P_PINS) begin
				assert (!user_ready) else report_failure("user_ready high during PRCH");
				prev_prch = 1'b1;
			end else begin
				assert (pins == NOOP_PINS)
					else report_mismatch("pins", 32'(pins), 32'(NOOP_PINS));
			end
		end
	end

	task automatic wait_drained();
		repeat (2) next_cycle(); // last command reaches pins
		assert (exp_q.size() == 0) else report_failure("accepted command never reached pins");
		assert (sent_cnt == seen_cnt) else report_mismatch("seen_cnt", seen_cnt, sent_cnt);
	endtask

	task automatic check_cke_rise();
		int n;
		n = 0;
		assert (cke == 1'b0) else report_mismatch("cke", 32'(cke), 32'd0);
		while (!cke) begin
			next_cycle();
			n++;
			if (n > CKE_WAIT + 4) report_failure("cke never rose after reset");
		end
		assert (n == CKE_WAIT) else report_mismatch("cke_delay", n, CKE_WAIT);
	endtask

	task automatic check_init_table();
		ddr2_pins_t want;
		for (int n = 1; n <= INIT_STEPS * STEP_GAP; n++) begin
			next_cycle();
			want = (n % STEP_GAP == 0) ? init_table[n / STEP_GAP - 1] : NOOP_PINS;
			assert (pins == want) else report_mismatch("pins", 32'(pins), 32'(want));
			assert (!user_ready && !init_done && cke)
				else report_failure("cke, init_done or user_ready wrong during init table");
		end
	endtask

	task automatic check_init_done();
		int n;
		n = 0;
		while (!init_done) begin
			next_cycle();
			n++;
			assert (!user_ready) else report_failure("user_ready high before init_done");
			assert (pins == NOOP_PINS) else report_mismatch("pins", 32'(pins), 32'(NOOP_PINS));
			if (n > SETTLE_WAIT + 4) report_failure("init_done never rose");
		end
		assert (n == SETTLE_WAIT) else report_mismatch("settle_delay", n, SETTLE_WAIT);
		done_cyc = cyc;
		mon_on = 1'b1;
	endtask

	task automatic check_user_traffic();
		logic [31:0] r;
		int          waited;
		for (int i = 0; i < USER_CMDS; i++) begin
			send_cmd(rand_user_cmd(), waited);
			r = next_rand();
			repeat (int'(r[31:30])) next_cycle(); // idle gap of 0 to 3
		end
		wait_drained();
	endtask

	task automatic check_refresh_pair();
		int waited;
		while (ref_pairs == 0) begin
			send_cmd(rand_user_cmd(), waited); // back to back traffic
			if (ref_pairs == 0 && cyc - done_cyc > REFRESH_INTERVAL + 3)
				report_failure("no refresh pair after init_done");
		end
		assert (ref_arsr_cyc - done_cyc <= REFRESH_INTERVAL + 3)
			else report_mismatch("ref_delay", ref_arsr_cyc - done_cyc, REFRESH_INTERVAL + 3);
		wait_drained();
	endtask

	task automatic check_held_valid();
		int         n;
		int         waited;
		int         seen_before;
		ddr2_pins_t c;
		n = 0;
		while (user_ready) begin
			next_cycle();
			n++;
			if (n > REFRESH_INTERVAL + 10) report_failure("second refresh never stalled the port");
		end
		seen_before = seen_cnt;
		c = rand_user_cmd();
		send_cmd(c, waited); // valid held across the stall
		assert (waited == STALL_CYCLES) else report_mismatch("stall_cycles", waited, STALL_CYCLES);
		wait_drained();
		assert (seen_cnt == seen_before + 1)
			else report_mismatch("seen_cnt", seen_cnt, seen_before + 1);
		assert (ref_pairs == 2) else report_mismatch("ref_pairs", ref_pairs, 2);
	endtask

	initial begin
		#(RUN_CYCLES * 10);
		report_failure("watchdog expired before the tests finished");
	end

	initial begin
		RST = 1'b0;
		user_valid = 1'b0;
		user_cmd = NOOP_PINS;
		load_init_table();
		repeat (16) @(posedge CLK_n);
		#1;
		RST = 1'b1;
		check_cke_rise();
		check_init_table();
		check_init_done();
		check_user_traffic();
		check_refresh_pair();
		check_held_valid();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: source/ddr2_cmd_arbiter.sv
`timescale 1ns/100ps

module ddr2_cmd_arbiter (
	input  logic                 CLK_n,
	input  logic                 RST,
	input  ddr2_pkg::ddr2_pins_t init_cmd,
	input  logic                 init_done,
	input  logic                 ref_req,
	input  ddr2_pkg::ddr2_pins_t user_cmd,
	input  logic                 user_valid,
	output logic                 user_ready,
	output logic                 ref_ack,
	output ddr2_pkg::ddr2_pins_t pins
);
	import ddr2_pkg::*;

	arb_state_e state;
	logic       accept; // user handshake this edge
	logic       ref_go; // fresh refresh request

	assign accept = user_valid && user_ready;
	// ref_req is still high in the ack cycle, do not restart on it
	assign ref_go = ref_req && !ref_ack;

	always_ff @(posedge CLK_n) begin
		if (!RST) begin
			state      <= IDLE;
			user_ready <= 1'b0;
			ref_ack    <= 1'b0;
			pins       <= NOP_PINS;
		end else begin
			ref_ack <= 1'b0; // single cycle pulse
			if (!init_done) begin
				state      <= IDLE;
				user_ready <= 1'b0; // user port closed during init
				pins       <= init_cmd;
			end else begin
				case (state)
					IDLE: begin
						pins <= accept ? user_cmd : NOP_PINS;
						if (ref_go) begin
							state      <= REF_PRCH; // refresh beats user
							user_ready <= 1'b0;
						end else begin
							user_ready <= 1'b1;
						end
					end
					REF_PRCH: begin
						pins  <= '{PRCH, PRCH_ALL_ADDR, 2'd0}; // close all banks
						state <= REF_ARSR;
					end
					REF_ARSR: begin
						pins    <= '{ARSR, PRCH_ALL_ADDR, 2'd0};
						ref_ack <= 1'b1; // timer drops ref_req next edge
						state   <= IDLE; // ready reopens from IDLE
					end
					default: begin
						pins  <= NOP_PINS;
						state <= IDLE;
					end
				endcase
			end
		end
	end

endmodule

// File: source/ddr2_cmd_top.sv
`timescale 1ns/100ps

module ddr2_cmd_top (
	input  logic                 CLK_n,
	input  logic                 RST,
	input  ddr2_pkg::ddr2_pins_t user_cmd,
	input  logic                 user_valid,
	output logic                 user_ready,
	output logic                 cke,
	output ddr2_pkg::ddr2_pins_t pins,
	output logic                 init_done
);
	import ddr2_pkg::*;

	ddr2_pins_t init_cmd; // init table slot, NOOP when idle
	logic       ref_req;  // timer to arbiter
	logic       ref_ack;  // arbiter to timer

	// power-up, cke and mode registers
	ddr2_init_seq u_init_seq (
		.CLK_n     (CLK_n),
		.RST       (RST),
		.cke       (cke),
		.init_cmd  (init_cmd),
		.init_done (init_done)
	);

	// periodic refresh request
	ddr2_refresh_timer u_refresh_timer (
		.CLK_n     (CLK_n),
		.RST       (RST),
		.init_done (init_done),
		.ref_ack   (ref_ack),
		.ref_req   (ref_req)
	);

	// init, refresh and user onto one set of pins
	ddr2_cmd_arbiter u_cmd_arbiter (
		.CLK_n      (CLK_n),
		.RST        (RST),
		.init_cmd   (init_cmd),
		.init_done  (init_done),
		.ref_req    (ref_req),
		.user_cmd   (user_cmd),
		.user_valid (user_valid),
		.user_ready (user_ready),
		.ref_ack    (ref_ack),
		.pins       (pins)
	);

endmodule

// File: source/ddr2_init_seq.sv
`timescale 1ns/100ps

module ddr2_init_seq (
	input  logic                 CLK_n,
	input  logic                 RST,
	output logic                 cke,
	output ddr2_pkg::ddr2_pins_t init_cmd,
	output logic                 init_done
);
	import ddr2_pkg::*;

	logic [INIT_CNT_W-1:0] cnt;        // shared by all three waits
	logic [STEP_W-1:0]     step;       // next table entry
	logic                  table_busy; // entries still to issue
	logic                  gap_hit;    // end of one command gap
	logic                  settle_hit; // end of settle wait

	assign table_busy = (step != STEP_W'(INIT_STEPS));
	assign gap_hit    = (cnt == INIT_CNT_W'(STEP_GAP - 1));
	assign settle_hit = (cnt == INIT_CNT_W'(SETTLE_WAIT));

	// DDR2 power-up command table
	function automatic ddr2_pins_t init_entry(input logic [STEP_W-1:0] idx);
		ddr2_pins_t e;
		case (idx)
			4'd0:    e = '{PRCH, PRCH_ALL_ADDR, 2'd1}; // precharge all
			4'd1:    e = '{MRST, 13'h000, 2'd2};       // EMR2
			4'd2:    e = '{MRST, 13'h000, 2'd3};       // EMR3
			4'd3:    e = '{MRST, 13'h380, 2'd1};       // EMR, OCD default
			4'd4:    e = '{MRST, 13'h532, 2'd0};       // MR with DLL reset
			4'd5:    e = '{PRCH, PRCH_ALL_ADDR, 2'd0}; // precharge all
			4'd6:    e = '{ARSR, PRCH_ALL_ADDR, 2'd0}; // first refresh
			4'd7:    e = '{ARSR, PRCH_ALL_ADDR, 2'd0}; // second refresh
			4'd8:    e = '{MRST, 13'h432, 2'd0};       // MR, DLL reset cleared
			4'd9:    e = '{MRST, 13'h380, 2'd1};       // EMR, OCD calibration default
			4'd10:   e = '{MRST, 13'h000, 2'd1};       // EMR, OCD exit
			default: e = NOP_PINS;
		endcase
		return e;
	endfunction

	always_ff @(posedge CLK_n) begin
		if (!RST) begin
			cke       <= 1'b0;
			init_done <= 1'b0;
			cnt       <= '0;
			step      <= '0;
			init_cmd  <= NOP_PINS;
		end else begin
			init_cmd <= NOP_PINS; // NOOP between table entries
			if (!cke) begin
				if (cnt == INIT_CNT_W'(CKE_WAIT - 1)) begin
					cke <= 1'b1;
					// gap phase starts one count ahead
					cnt <= INIT_CNT_W'(1);
				end else begin
					cnt <= cnt + 1'b1;
				end
			end else if (table_busy) begin
				if (gap_hit) begin
					init_cmd <= init_entry(step); // arbiter adds one more stage
					step     <= step + 1'b1;
					cnt      <= '0;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end else if (!init_done) begin
				if (settle_hit) begin
					init_done <= 1'b1; // held until reset
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

endmodule

// File: source/ddr2_pkg.sv
package ddr2_pkg;

	// DDR2 command pins, {ras_n, cas_n, we_n}
	typedef enum logic [2:0] {
		MRST = 3'b000, // mode register set
		ARSR = 3'b001, // auto refresh / self refresh
		PRCH = 3'b010, // precharge, row close
		ACTV = 3'b011, // activate, row open
		WRTE = 3'b100, // write
		READ = 3'b101, // read
		BTRM = 3'b110, // burst terminate
		NOOP = 3'b111  // no operation
	} ddr2_cmd_e;

	// one command slot as seen on the pins, 18 bits
	typedef struct packed {
		ddr2_cmd_e   cmd;  // command encoding
		logic [12:0] addr; // A12..A0
		logic [1:0]  bank; // BA1..BA0
	} ddr2_pins_t;

	// arbiter refresh insertion
	typedef enum logic [1:0] {
		IDLE     = 2'd0, // user port open
		REF_PRCH = 2'd1, // precharge-all goes out next
		REF_ARSR = 2'd2  // auto refresh goes out next
	} arb_state_e;

	// cycle counts, shortened for simulation
	localparam int CKE_WAIT         = 200; // cke low after reset
	localparam int STEP_GAP         = 32;  // spacing of init commands
	localparam int INIT_STEPS       = 11;  // init table length
	localparam int SETTLE_WAIT      = 256; // last init command to init_done
	localparam int REFRESH_INTERVAL = 390; // between refresh requests

	localparam int INIT_CNT_W = 9; // holds up to SETTLE_WAIT
	localparam int STEP_W     = 4; // holds up to INIT_STEPS
	localparam int REF_CNT_W  = 9; // holds up to REFRESH_INTERVAL

	localparam logic [12:0] PRCH_ALL_ADDR = 13'h400; // A10 high, all banks

	// idle pins, NOOP with A10 held high
	localparam ddr2_pins_t NOP_PINS = '{cmd: NOOP, addr: PRCH_ALL_ADDR, bank: 2'd0};

endpackage

// File: source/ddr2_refresh_timer.sv
`timescale 1ns/100ps

module ddr2_refresh_timer (
	input  logic CLK_n,
	input  logic RST,
	input  logic init_done,
	input  logic ref_ack,
	output logic ref_req
);
	import ddr2_pkg::*;

	logic [REF_CNT_W-1:0] cnt; // cycles since last request cleared
	logic                 interval_hit;

	assign interval_hit = (cnt == REF_CNT_W'(REFRESH_INTERVAL - 1));

	always_ff @(posedge CLK_n) begin
		if (!RST) begin
			cnt     <= '0;
			ref_req <= 1'b0;
		end else if (ref_req) begin
			// hold until the arbiter has issued the pair
			if (ref_ack) begin
				ref_req <= 1'b0;
			end
		end else if (init_done) begin
			if (interval_hit) begin
				ref_req <= 1'b1;
				cnt     <= '0; // restart after ack
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule
